// File: ttlMemoryBridge.f
logic/ttlBridgePkg.sv
logic/mstBusPkg.sv
logic/ttlBusSync.sv
logic/intrHandshake.sv
logic/mstCmdPort.sv
logic/ttlMemoryBusMaster.sv
logic/hostRegs.sv
logic/ttlMemoryBridge.sv
dv/mstMemModel.sv
dv/ttlMemoryBridgeTb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile the bridge and its testbench with Verilator, then run the simulation
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f ttlMemoryBridge.f \
	--top-module ttlMemoryBridgeTb \
	--Mdir obj_dir \
	-o ttlMemoryBridgeSim

./obj_dir/ttlMemoryBridgeSim

// File: dv/ttlMemoryBridgeTb.sv
`timescale 1ns/10ps

module ttlMemoryBridgeTb;
	import ttlBridgePkg::*;
	import mstBusPkg::*;

	localparam int addrWidth = 16;
	localparam logic [31:0] baseAddr = 32'h0000_0100;
	// About 60 TTL cycles of under 200 clocks each, with margin
	localparam int cyclesPerTransaction = 200;
	localparam int transactionBudget = 100;
	localparam int timeoutCycles = cyclesPerTransaction * transactionBudget;

	typedef struct packed {
		logic write;
		logic [31:0] addr;
		logic [3:0] be;
		logic [31:0] wdata;
	} accessT;

	typedef struct packed {
		logic [31:0] addr;
		logic [3:0] be;
		logic [7:0] rbyte;
	} expectT;

	logic clk = 1'b0;
	logic rst_n;
	logic nChipEnable;
	logic nOutputEnable;
	logic nWriteEnable;
	logic [addrWidth-1:0] address;
	logic [7:0] dataIn;
	logic [7:0] dataOut;
	logic dataOutEnable;
	hostReqT hostReq;
	logic [31:0] hostRdata;
	intrSetT intr;
	mstReqT mstReq;
	mstRspT mstRsp;
	logic accessValid;
	logic accessWrite;
	logic [31:0] accessAddr;
	logic [3:0] accessBe;
	logic [31:0] accessWdata;

	logic [7:0] shadow [1024];
	logic [31:0] mappedAddr;
	logic [addrWidth-1:0] addrSubstValue;
	logic [7:0] dataSubstValue;
	logic [31:0] lcgState;
	accessT accessQ [$];
	logic [7:0] readQ [$];
	logic dataOutEnablePrev;
	int cycleCount = 0;

	ttlMemoryBridge #(.addrWidth(addrWidth), .syncStages(2)) ttlMemoryBridge_i (.*);

	mstMemModel #(.lcgSeed(32'h855f)) memModel_i (.*);

	always #4 clk = ~clk;

	function automatic logic [31:0] drawRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState >> 16;
	endfunction

	function automatic logic [7:0] fillByte(input logic [9:0] byteAddr);
		return 8'(byteAddr[7:0] * 8'd7) ^ {4{byteAddr[9:8]}};
	endfunction

	// Mapped address, byte lane and the byte the memory should return
	function automatic expectT expectedAccess(input logic [addrWidth-1:0] ttlAddr);
		expectT e;
		e.addr = mappedAddr + 32'(ttlAddr);
		e.be = 4'b0001 << e.addr[1:0];
		e.rbyte = (e.addr < 32'd1024) ? shadow[e.addr[9:0]] : 8'h00;
		return e;
	endfunction

	function automatic logic [31:0] controlWord(input logic [2:0] irq);
		return {28'd0, irq, 1'b1};
	endfunction

	// Valid only while the host selector rests on Status
	function automatic bridgeStateT currentState();
		return bridgeStateT'(hostRdata[statusStateLsb +: 5]);
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Fail at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic stepCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic hostWrite(input regSelT sel, input logic [31:0] value);
		hostReq = '{write: 1'b1, sel: sel, wdata: value};
		stepCycle();
		hostReq = '{write: 1'b0, sel: Status, wdata: 32'd0};
	endtask

	// Readback is combinational, so the selector only has to settle
	task automatic checkRegister(input string name, input regSelT sel,
			input logic [31:0] expected);
		hostReq = '{write: 1'b0, sel: sel, wdata: 32'd0};
		#1;
		checkValue(name, expected, hostRdata);
		hostReq = '{write: 1'b0, sel: Status, wdata: 32'd0};
	endtask

	task automatic waitState(input bridgeStateT target);
		while (currentState() != target) begin
			stepCycle();
		end
	endtask

	task automatic idleWindow(input int cycles);
		repeat (cycles) begin
			stepCycle();
			checkValue("Status state", 32'(Disabled), 32'(currentState()));
			checkValue("mstReq.rdReq", 32'd0, 32'(mstReq.rdReq));
			checkValue("mstReq.wrReq", 32'd0, 32'(mstReq.wrReq));
			checkValue("dataOutEnable", 32'd0, 32'(dataOutEnable));
		end
	endtask

	// Acknowledge every raised line as the host would until the cycle responds
	task automatic serviceUntilRespond(output logic [2:0] seen);
		logic [2:0] raised;
		seen = 3'b000;
		while (currentState() != Respond) begin
			raised = intr;
			if (raised != 3'b000) begin
				seen = seen | raised;
				repeat (3) begin
					stepCycle();
					checkValue("intr", 32'(raised), 32'(intr));
				end
				hostWrite(IntrStatus, {29'd0, raised});
				while ((intr & raised) != 3'b000) begin
					stepCycle();
				end
				hostWrite(IntrStatus, 32'd0);
			end else begin
				stepCycle();
			end
		end
	endtask

	// irq bits are address, read, write as in the Control register
	task automatic ttlCycle(input logic write, input logic [addrWidth-1:0] pinAddr,
			input logic [7:0] pinData, input logic [2:0] irq);
		logic [addrWidth-1:0] effAddr;
		logic [7:0] effData;
		logic [2:0] seen;
		expectT e;
		effAddr = irq[2] ? addrSubstValue : pinAddr;
		e = expectedAccess(effAddr);
		if (write) begin
			effData = irq[0] ? dataSubstValue : pinData;
			accessQ.push_back('{write: 1'b1, addr: e.addr, be: e.be, wdata: {4{effData}}});
			if (e.addr < 32'd1024) begin
				shadow[e.addr[9:0]] = effData;
			end
		end else begin
			effData = irq[1] ? dataSubstValue : e.rbyte;
			accessQ.push_back('{write: 1'b0, addr: e.addr, be: e.be, wdata: 32'd0});
			readQ.push_back(effData);
		end
		address = pinAddr;
		dataIn = pinData;
		nChipEnable = 1'b0;
		nWriteEnable = !write;
		nOutputEnable = write;
		serviceUntilRespond(seen);
		checkValue("intr serviced", 32'(irq & (write ? 3'b101 : 3'b110)), 32'(seen));
		checkValue("dataOutEnable", 32'(!write), 32'(dataOutEnable));
		nChipEnable = 1'b1;
		nWriteEnable = 1'b1;
		nOutputEnable = 1'b1;
		waitState(Idle);
		checkValue("pending master accesses", 32'd0, 32'(accessQ.size()));
		checkValue("pending read responses", 32'd0, 32'(readQ.size()));
	endtask

	// Every completed master access is matched to the oldest TTL cycle
	always @(posedge clk) begin : accessCheck
		accessT expAccess;
		if (rst_n && accessValid && accessQ.size() == 0) begin
			$display("Master bus access to %h arrived with no TTL cycle outstanding", accessAddr);
			$display("TEST FAILED");
			$fatal(1, "Unexpected master access");
		end else if (rst_n && accessValid) begin
			expAccess = accessQ.pop_front();
			checkValue("mstReq.wrReq", 32'(expAccess.write), 32'(accessWrite));
			checkValue("mstReq.addr", expAccess.addr, accessAddr);
			checkValue("mstReq.be", 32'(expAccess.be), 32'(accessBe));
			if (expAccess.write) begin
				checkValue("mstReq.wdata", expAccess.wdata, accessWdata);
			end
		end
	end

	always @(posedge clk) begin : dataOutCheck
		if (rst_n && dataOutEnable && !dataOutEnablePrev && readQ.size() == 0) begin
			$display("dataOutEnable rose while no TTL read was outstanding");
			$display("TEST FAILED");
			$fatal(1, "Unexpected read response");
		end else if (rst_n && dataOutEnable && !dataOutEnablePrev) begin
			checkValue("dataOut", 32'(readQ.pop_front()), 32'(dataOut));
		end
	end

	always @(posedge clk) begin
		dataOutEnablePrev <= rst_n && dataOutEnable;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("Run stopped after %0d cycles, the bridge did not finish the tests", cycleCount);
			$display("TEST FAILED");
			$fatal(1, "Timeout");
		end
	end

	initial begin
		rst_n = 1'b0;
		nChipEnable = 1'b1;
		nOutputEnable = 1'b1;
		nWriteEnable = 1'b1;
		address = '0;
		dataIn = 8'h00;
		hostReq = '{write: 1'b0, sel: Status, wdata: 32'd0};
		mappedAddr = 32'd0;
		addrSubstValue = '0;
		dataSubstValue = 8'h00;
		lcgState = 32'h855f;
		for (int a = 0; a < 1024; a++) begin
			shadow[a] = fillByte(10'(a));
		end
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		stepCycle();

		// Disabled bridge ignores the TTL pins
		checkValue("Status state", 32'(Disabled), 32'(currentState()));
		address = 16'h0040;
		dataIn = 8'h5A;
		nChipEnable = 1'b0;
		nWriteEnable = 1'b0;
		idleWindow(12);
		nWriteEnable = 1'b1;
		nOutputEnable = 1'b0;
		idleWindow(12);
		nChipEnable = 1'b1;
		nOutputEnable = 1'b1;
		idleWindow(4);

		hostWrite(MappedAddr, baseAddr);
		mappedAddr = baseAddr;
		hostWrite(Control, controlWord(3'b000));
		waitState(Idle);
		checkValue("Status enable bit", 32'd1, 32'(hostRdata[statusEnableBit]));
		checkValue("Status error bit", 32'd0, 32'(hostRdata[statusErrorBit]));

		// Writes stay in a small window so the reads hit them
		for (int n = 0; n < 16; n++) begin
			ttlCycle(1'b1, 16'(drawRandom() % 32'd64), 8'(drawRandom()), 3'b000);
		end
		for (int n = 0; n < 16; n++) begin
			ttlCycle(1'b0, 16'(drawRandom() % 32'd64), 8'h00, 3'b000);
		end
		for (int n = 0; n < 8; n++) begin
			ttlCycle(1'b0, 16'(drawRandom() % 32'd512), 8'h00, 3'b000);
		end

		addrSubstValue = 16'h0123;
		hostWrite(AddrWrite, 32'(addrSubstValue));
		hostWrite(Control, controlWord(3'b100));
		ttlCycle(1'b1, 16'h0007, 8'h9E, 3'b100);
		ttlCycle(1'b0, 16'h0031, 8'h00, 3'b100);
		checkRegister("AddrRead", AddrRead, 32'(addrSubstValue));

		dataSubstValue = 8'hC3;
		hostWrite(DataWrite, 32'(dataSubstValue));
		hostWrite(Control, controlWord(3'b011));
		ttlCycle(1'b1, 16'h0010, 8'h11, 3'b011);
		ttlCycle(1'b0, 16'h0020, 8'h00, 3'b011);
		checkRegister("AddrRead", AddrRead, 32'h0000_0020);
		checkRegister("DataRead", DataRead, 32'(dataSubstValue));
		hostWrite(Control, controlWord(3'b111));
		ttlCycle(1'b1, 16'h0002, 8'h44, 3'b111);
		ttlCycle(1'b0, 16'h0003, 8'h00, 3'b111);
		hostWrite(Control, controlWord(3'b000));
		ttlCycle(1'b0, 16'h0010, 8'h00, 3'b000);
		ttlCycle(1'b0, 16'h0123, 8'h00, 3'b000);

		// Beyond the 1 KiB image the slave answers with an error
		hostWrite(MappedAddr, 32'h0010_0000);
		mappedAddr = 32'h0010_0000;
		ttlCycle(1'b1, 16'h0004, 8'h77, 3'b000);
		checkValue("Status error bit", 32'd1, 32'(hostRdata[statusErrorBit]));
		hostWrite(MappedAddr, baseAddr);
		mappedAddr = baseAddr;
		for (int n = 0; n < 4; n++) begin
			ttlCycle(1'b1, 16'(drawRandom() % 32'd64), 8'(drawRandom()), 3'b000);
			ttlCycle(1'b0, 16'(drawRandom() % 32'd64), 8'h00, 3'b000);
		end
		checkValue("Status error bit", 32'd1, 32'(hostRdata[statusErrorBit]));

		$display("TEST OK");
		$finish;
	end

endmodule

// File: dv/mstMemModel.sv
`timescale 1ns/10ps

module mstMemModel #(
	parameter logic [31:0] lcgSeed = 32'h855f
) (
	input logic clk,
	input logic rst_n,
	input mstBusPkg::mstReqT mstReq,
	output mstBusPkg::mstRspT mstRsp,
	output logic accessValid,
	output logic accessWrite,
	output logic [31:0] accessAddr,
	output logic [3:0] accessBe,
	output logic [31:0] accessWdata
);
	import mstBusPkg::*;

	typedef enum logic [1:0] {
		WaitReq,
		AckWait,
		CmpltWait
	} slavePhaseT;

	logic [31:0] mem [256];
	slavePhaseT phase;
	logic [31:0] lcgState;
	logic [1:0] delay;
	logic outOfRange;

	function automatic logic [31:0] nextRandom(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Each byte of the image depends on its full byte address
	function automatic logic [7:0] fillByte(input logic [9:0] byteAddr);
		return 8'(byteAddr[7:0] * 8'd7) ^ {4{byteAddr[9:8]}};
	endfunction

	initial begin
		for (int w = 0; w < 256; w++) begin
			for (int l = 0; l < 4; l++) begin
				mem[w][l*8 +: 8] = fillByte(10'(w * 4 + l));
			end
		end
	end

	// 1 KiB image, anything above it answers with an error
	assign outOfRange = accessAddr[31:10] != 22'd0;

	always @(posedge clk) begin : slave
		logic [31:0] drawn;
		drawn = nextRandom(lcgState);
		if (!rst_n) begin
			phase <= WaitReq;
			lcgState <= lcgSeed;
			delay <= 2'd0;
			mstRsp <= '0;
			accessValid <= 1'b0;
		end else begin
			mstRsp.cmdAck <= 1'b0;
			mstRsp.cmplt <= 1'b0;
			mstRsp.error <= 1'b0;
			accessValid <= 1'b0;
			case (phase)
				WaitReq: begin
					if (mstReq.rdReq || mstReq.wrReq) begin
						delay <= drawn[17:16];
						lcgState <= drawn;
						phase <= AckWait;
					end
				end
				AckWait: begin
					if (delay != 2'd0) begin
						delay <= delay - 2'd1;
					end else begin
						mstRsp.cmdAck <= 1'b1;
						accessWrite <= mstReq.wrReq;
						accessAddr <= mstReq.addr;
						accessBe <= mstReq.be;
						accessWdata <= mstReq.wdata;
						delay <= drawn[17:16];
						lcgState <= drawn;
						phase <= CmpltWait;
					end
				end
				CmpltWait: begin
					if (delay != 2'd0) begin
						delay <= delay - 2'd1;
					end else begin
						mstRsp.cmplt <= 1'b1;
						mstRsp.error <= outOfRange;
						mstRsp.rdata <= outOfRange ? 32'd0 : mem[accessAddr[9:2]];
						for (int l = 0; l < 4; l++) begin
							if (accessWrite && !outOfRange && accessBe[l]) begin
								mem[accessAddr[9:2]][l*8 +: 8] = accessWdata[l*8 +: 8];
							end
						end
						accessValid <= 1'b1;
						phase <= WaitReq;
					end
				end
				default: phase <= WaitReq;
			endcase
		end
	end

endmodule

// File: logic/ttlMemoryBridge.sv
`timescale 1ns/10ps

module ttlMemoryBridge #(
	parameter int addrWidth = 16,
	parameter int syncStages = 2
) (
	input logic clk,
	input logic rst_n,
	input logic nChipEnable,
	input logic nOutputEnable,
	input logic nWriteEnable,
	input logic [addrWidth-1:0] address,
	input logic [ttlBridgePkg::dataWidth-1:0] dataIn,
	output logic [ttlBridgePkg::dataWidth-1:0] dataOut,
	output logic dataOutEnable,
	input ttlBridgePkg::hostReqT hostReq,
	output logic [31:0] hostRdata,
	output ttlBridgePkg::intrSetT intr,
	output mstBusPkg::mstReqT mstReq,
	input mstBusPkg::mstRspT mstRsp
);
	import ttlBridgePkg::*;
	import mstBusPkg::*;

	ttlCycleT cycle;
	logic [addrWidth-1:0] syncAddress;
	logic enable;
	intrSetT intrEnable;
	intrSetT intrStatus;
	intrSetT intrStart;
	intrSetT intrDone;
	logic [mstAddrWidth-1:0] mappedAddress;
	logic [addrWidth-1:0] addrSubst;
	logic [dataWidth-1:0] dataSubst;
	mstOpT op;
	logic [mstAddrWidth-1:0] mstAddr;
	logic [dataWidth-1:0] wbyte;
	logic mstDone;
	logic [dataWidth-1:0] rbyte;
	logic mstError;
	bridgeStateT state;
	logic [addrWidth-1:0] busAddress;
	logic [dataWidth-1:0] busData;
	logic errorSticky;

	ttlBusSync #(.addrWidth(addrWidth), .syncStages(syncStages)) ttlBusSync_i (.*);

	hostRegs #(.addrWidth(addrWidth)) hostRegs_i (.*);

	ttlMemoryBusMaster #(.addrWidth(addrWidth)) ttlMemoryBusMaster_i (.*);

	mstCmdPort mstCmdPort_i (
		.*,
		.addr(mstAddr),
		.done(mstDone),
		.error(mstError)
	);

	// One handshake per substitution point
	intrHandshake addrIntr_i (
		.clk(clk),
		.rst_n(rst_n),
		.enable(intrEnable.address),
		.start(intrStart.address),
		.hostStatus(intrStatus.address),
		.intr(intr.address),
		.done(intrDone.address)
	);

	intrHandshake readIntr_i (
		.clk(clk),
		.rst_n(rst_n),
		.enable(intrEnable.read),
		.start(intrStart.read),
		.hostStatus(intrStatus.read),
		.intr(intr.read),
		.done(intrDone.read)
	);

	intrHandshake writeIntr_i (
		.clk(clk),
		.rst_n(rst_n),
		.enable(intrEnable.write),
		.start(intrStart.write),
		.hostStatus(intrStatus.write),
		.intr(intr.write),
		.done(intrDone.write)
	);

endmodule

// File: logic/hostRegs.sv
`timescale 1ns/10ps

module hostRegs #(
	parameter int addrWidth = 16
) (
	input logic clk,
	input logic rst_n,
	input ttlBridgePkg::hostReqT hostReq,
	input ttlBridgePkg::bridgeStateT state,
	input logic [addrWidth-1:0] busAddress,
	input logic [ttlBridgePkg::dataWidth-1:0] busData,
	input logic errorSticky,
	output logic [31:0] hostRdata,
	output logic enable,
	output ttlBridgePkg::intrSetT intrEnable,
	output ttlBridgePkg::intrSetT intrStatus,
	output logic [31:0] mappedAddress,
	output logic [addrWidth-1:0] addrSubst,
	output logic [ttlBridgePkg::dataWidth-1:0] dataSubst
);
	import ttlBridgePkg::*;

	// Enable in bit 0, interrupt enables above it
	logic [ctrlIntrLsb+$bits(intrSetT)-1:0] control;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			control <= '0;
			intrStatus <= '0;
			mappedAddress <= '0;
			addrSubst <= '0;
			dataSubst <= '0;
		end else if (hostReq.write) begin
			case (hostReq.sel)
				Control: control <= hostReq.wdata[$bits(control)-1:0];
				AddrWrite: addrSubst <= hostReq.wdata[addrWidth-1:0];
				DataWrite: dataSubst <= hostReq.wdata[dataWidth-1:0];
				IntrStatus: intrStatus <= intrSetT'(hostReq.wdata[$bits(intrSetT)-1:0]);
				MappedAddr: mappedAddress <= hostReq.wdata;
				default: begin
				end
			endcase
		end
	end

	assign enable = control[ctrlEnableBit];
	assign intrEnable = intrSetT'(control[ctrlIntrLsb +: $bits(intrSetT)]);

	always_comb begin
		hostRdata = '0;
		case (hostReq.sel)
			Control: hostRdata[$bits(control)-1:0] = control;
			Status: begin
				hostRdata[statusStateLsb +: $bits(bridgeStateT)] = state;
				hostRdata[statusErrorBit] = errorSticky;
				hostRdata[statusEnableBit] = enable;
			end
			AddrWrite: hostRdata[addrWidth-1:0] = addrSubst;
			DataWrite: hostRdata[dataWidth-1:0] = dataSubst;
			IntrStatus: hostRdata[$bits(intrSetT)-1:0] = intrStatus;
			AddrRead: hostRdata[addrWidth-1:0] = busAddress;
			DataRead: hostRdata[dataWidth-1:0] = busData;
			MappedAddr: hostRdata = mappedAddress;
			default: begin
			end
		endcase
	end

endmodule

// File: logic/ttlMemoryBusMaster.sv
`timescale 1ns/10ps

module ttlMemoryBusMaster #(
	parameter int addrWidth = 16
) (
	input logic clk,
	input logic rst_n,
	input ttlBridgePkg::ttlCycleT cycle,
	input logic [addrWidth-1:0] syncAddress,
	input logic enable,
	input ttlBridgePkg::intrSetT intrEnable,
	input logic [mstBusPkg::mstAddrWidth-1:0] mappedAddress,
	input logic [addrWidth-1:0] addrSubst,
	input logic [ttlBridgePkg::dataWidth-1:0] dataSubst,
	input ttlBridgePkg::intrSetT intrDone,
	input logic mstDone,
	input logic [ttlBridgePkg::dataWidth-1:0] rbyte,
	input logic mstError,
	output ttlBridgePkg::intrSetT intrStart,
	output mstBusPkg::mstOpT op,
	output logic [mstBusPkg::mstAddrWidth-1:0] mstAddr,
	output logic [ttlBridgePkg::dataWidth-1:0] wbyte,
	output ttlBridgePkg::bridgeStateT state,
	output logic [addrWidth-1:0] busAddress,
	output logic [ttlBridgePkg::dataWidth-1:0] busData,
	output logic [ttlBridgePkg::dataWidth-1:0] dataOut,
	output logic dataOutEnable,
	output logic errorSticky
);
	import ttlBridgePkg::*;
	import mstBusPkg::*;

	// Direction of the TTL cycle in progress
	logic writeCycle;
	logic strobe;

	assign strobe = cycle.chipEnable && (cycle.writeEnable || cycle.outputEnable);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= Disabled;
			writeCycle <= 1'b0;
			intrStart <= '0;
			op <= MstIdle;
			errorSticky <= 1'b0;
		end else begin
			intrStart <= '0;
			op <= MstIdle;
			case (state)
				Disabled: begin
					if (enable) begin
						state <= Idle;
					end
				end
				Idle: begin
					if (!enable) begin
						state <= Disabled;
					end else if (strobe) begin
						writeCycle <= cycle.writeEnable;
						if (intrEnable.address) begin
							intrStart.address <= 1'b1;
							state <= AddrIntr;
						end else if (cycle.writeEnable) begin
							state <= WriteCapture;
						end else begin
							state <= MstAddr;
						end
					end
				end
				AddrIntr: begin
					if (intrDone.address) begin
						state <= writeCycle ? WriteCapture : MstAddr;
					end
				end
				// Read address is final here
				MstAddr: begin
					op <= MstRd;
					state <= MstRead;
				end
				WriteCapture: begin
					if (intrEnable.write) begin
						intrStart.write <= 1'b1;
						state <= WriteIntr;
					end else begin
						op <= MstWr;
						state <= MstWrite;
					end
				end
				WriteIntr: begin
					if (intrDone.write) begin
						op <= MstWr;
						state <= MstWrite;
					end
				end
				MstWrite: begin
					if (mstDone) begin
						state <= Respond;
					end
				end
				MstRead: begin
					if (mstDone && intrEnable.read) begin
						intrStart.read <= 1'b1;
						state <= ReadIntr;
					end else if (mstDone) begin
						state <= Respond;
					end
				end
				ReadIntr: begin
					if (intrDone.read) begin
						state <= Respond;
					end
				end
				// Hold the response until the device ends the cycle
				Respond: begin
					if (!cycle.chipEnable) begin
						state <= Idle;
					end
				end
				default: state <= Disabled;
			endcase
			if (mstDone && mstError) begin
				errorSticky <= 1'b1;
			end
		end
	end

	// Address and data of the current cycle, host substitutions land here too
	always_ff @(posedge clk) begin
		case (state)
			Idle: busAddress <= syncAddress;
			AddrIntr: begin
				if (intrDone.address) begin
					busAddress <= addrSubst;
				end
			end
			WriteCapture: busData <= cycle.data;
			WriteIntr: begin
				if (intrDone.write) begin
					busData <= dataSubst;
				end
			end
			MstRead: begin
				if (mstDone) begin
					busData <= rbyte;
				end
			end
			ReadIntr: begin
				if (intrDone.read) begin
					busData <= dataSubst;
				end
			end
			default: begin
			end
		endcase
	end

	assign mstAddr = mappedAddress + mstAddrWidth'(busAddress);
	assign wbyte = busData;
	assign dataOut = busData;
	assign dataOutEnable = (state == Respond) && !writeCycle
		&& cycle.chipEnable && cycle.outputEnable;

	// Command port completions only arrive while a transfer is outstanding
	assert property (@(posedge clk) disable iff (!rst_n)
		mstDone |-> state inside {MstRead, MstWrite});

endmodule

// File: logic/mstCmdPort.sv
`timescale 1ns/10ps

module mstCmdPort (
	input logic clk,
	input logic rst_n,
	input mstBusPkg::mstOpT op,
	input logic [mstBusPkg::mstAddrWidth-1:0] addr,
	input logic [ttlBridgePkg::dataWidth-1:0] wbyte,
	input mstBusPkg::mstRspT mstRsp,
	output mstBusPkg::mstReqT mstReq,
	output logic done,
	output logic [ttlBridgePkg::dataWidth-1:0] rbyte,
	output logic error
);
	import ttlBridgePkg::*;
	import mstBusPkg::*;

	localparam int laneCount = mstDataWidth / dataWidth;
	localparam int laneBits = $clog2(laneCount);

	logic rdReq;
	logic wrReq;
	logic active;
	logic launch;
	logic [mstAddrWidth-1:0] reqAddr;
	logic [laneCount-1:0] reqBe;
	logic [mstDataWidth-1:0] reqData;

	// A new op is only taken when no transfer is outstanding
	assign launch = !active && (op != MstIdle);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rdReq <= 1'b0;
			wrReq <= 1'b0;
			active <= 1'b0;
			done <= 1'b0;
			error <= 1'b0;
		end else begin
			done <= 1'b0;
			if (launch) begin
				rdReq <= (op == MstRd);
				wrReq <= (op == MstWr);
				active <= 1'b1;
			end else if (active) begin
				if (mstRsp.cmdAck) begin
					rdReq <= 1'b0;
					wrReq <= 1'b0;
				end
				if (mstRsp.cmplt) begin
					active <= 1'b0;
					done <= 1'b1;
					error <= mstRsp.error;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (launch) begin
			reqAddr <= addr;
			reqBe <= laneCount'(1) << addr[laneBits-1:0];
			reqData <= {laneCount{wbyte}};
		end
		// Pick the addressed lane out of the returned word
		if (active && mstRsp.cmplt) begin
			rbyte <= mstRsp.rdata[reqAddr[laneBits-1:0]*dataWidth +: dataWidth];
		end
	end

	assign mstReq = '{rdReq: rdReq, wrReq: wrReq, addr: reqAddr, be: reqBe, wdata: reqData};

	assert property (@(posedge clk) disable iff (!rst_n) !(rdReq && wrReq));

	// Whole request stays put until the slave accepts it
	assert property (@(posedge clk) disable iff (!rst_n)
		(mstReq.rdReq || mstReq.wrReq) && !mstRsp.cmdAck |=> $stable(mstReq));

endmodule

// File: logic/intrHandshake.sv
`timescale 1ns/10ps

module intrHandshake (
	input logic clk,
	input logic rst_n,
	input logic enable,
	input logic start,
	input logic hostStatus,
	output logic intr,
	output logic done
);
	typedef enum logic [1:0] {
		Quiet,
		Raised,
		Acked
	} phaseT;

	phaseT phase;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase <= Quiet;
			intr <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (phase)
				Quiet: begin
					if (start && enable) begin
						phase <= Raised;
					end else if (start) begin
						// Nothing for the host to do
						done <= 1'b1;
					end
				end
				// Hold off until a stale status bit has been cleared
				Raised: begin
					if (!intr && !hostStatus) begin
						intr <= 1'b1;
					end else if (intr && hostStatus) begin
						intr <= 1'b0;
						phase <= Acked;
					end
				end
				Acked: begin
					if (!hostStatus) begin
						done <= 1'b1;
						phase <= Quiet;
					end
				end
				default: phase <= Quiet;
			endcase
		end
	end

	// Host status must have read 0 on the edge that raised the line
	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(intr) |-> !$past(hostStatus));

endmodule

// File: logic/ttlBusSync.sv
`timescale 1ns/10ps

module ttlBusSync #(
	parameter int addrWidth = 16,
	parameter int syncStages = 2
) (
	input logic clk,
	input logic rst_n,
	input logic nChipEnable,
	input logic nOutputEnable,
	input logic nWriteEnable,
	input logic [addrWidth-1:0] address,
	input logic [ttlBridgePkg::dataWidth-1:0] dataIn,
	output ttlBridgePkg::ttlCycleT cycle,
	output logic [addrWidth-1:0] syncAddress
);
	import ttlBridgePkg::*;

	// Stage 0 samples the pins, the last stage feeds the bridge
	logic [2:0] strobeSync [syncStages];
	logic [addrWidth-1:0] addrSync [syncStages];
	logic [dataWidth-1:0] dataSync [syncStages];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < syncStages; i++) begin
				strobeSync[i] <= '0;
			end
		end else begin
			// Pins are active low
			strobeSync[0] <= {~nChipEnable, ~nOutputEnable, ~nWriteEnable};
			for (int i = 1; i < syncStages; i++) begin
				strobeSync[i] <= strobeSync[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		addrSync[0] <= address;
		dataSync[0] <= dataIn;
		for (int i = 1; i < syncStages; i++) begin
			addrSync[i] <= addrSync[i-1];
			dataSync[i] <= dataSync[i-1];
		end
	end

	assign cycle = '{
		chipEnable: strobeSync[syncStages-1][2],
		outputEnable: strobeSync[syncStages-1][1],
		writeEnable: strobeSync[syncStages-1][0],
		data: dataSync[syncStages-1]
	};
	assign syncAddress = addrSync[syncStages-1];

	// The external device never reads and writes in the same TTL cycle
	assert property (@(posedge clk) disable iff (!rst_n)
		cycle.chipEnable |-> !(cycle.outputEnable && cycle.writeEnable));

endmodule

// File: logic/mstBusPkg.sv
package mstBusPkg;

	localparam int mstAddrWidth = 32;
	localparam int mstDataWidth = 32;

	typedef enum logic [1:0] {
		MstIdle,
		MstRd,
		MstWr
	} mstOpT;

	// Request levels hold until cmdAck
	typedef struct packed {
		logic rdReq;
		logic wrReq;
		logic [mstAddrWidth-1:0] addr;
		logic [mstDataWidth/8-1:0] be;
		logic [mstDataWidth-1:0] wdata;
	} mstReqT;

	// rdata is valid in the cmplt cycle
	typedef struct packed {
		logic cmdAck;
		logic cmplt;
		logic error;
		logic [mstDataWidth-1:0] rdata;
	} mstRspT;

endpackage

// File: logic/ttlBridgePkg.sv
package ttlBridgePkg;

	// TTL data bus is one byte, the lane logic relies on it
	localparam int dataWidth = 8;

	// Register map bit positions
	localparam int ctrlEnableBit = 0;
	localparam int ctrlIntrLsb = 1;
	localparam int statusEnableBit = 0;
	localparam int statusErrorBit = 1;
	localparam int statusStateLsb = 8;

	// Code is visible to the host in the status register
	typedef enum logic [4:0] {
		Disabled     = 5'd0,
		Idle         = 5'd1,
		AddrIntr     = 5'd2,
		MstAddr      = 5'd3,
		WriteCapture = 5'd4,
		WriteIntr    = 5'd5,
		MstWrite     = 5'd6,
		MstRead      = 5'd7,
		ReadIntr     = 5'd8,
		Respond      = 5'd9
	} bridgeStateT;

	// Strobes are active high once synchronised
	typedef struct packed {
		logic chipEnable;
		logic outputEnable;
		logic writeEnable;
		logic [dataWidth-1:0] data;
	} ttlCycleT;

	typedef enum logic [2:0] {
		Control,
		Status,
		AddrWrite,
		DataWrite,
		IntrStatus,
		AddrRead,
		DataRead,
		MappedAddr
	} regSelT;

	typedef struct packed {
		logic write;
		regSelT sel;
		logic [31:0] wdata;
	} hostReqT;

	typedef struct packed {
		logic address;
		logic read;
		logic write;
	} intrSetT;

endpackage
